// File: run.sh
#!/bin/sh
# builds the wave-table mixer testbench with Verilator, runs it and judges the log

LOG=sim.log
OBJ_DIR=obj_dir
TOP=wts_tb

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f sources.f --Mdir "$OBJ_DIR"; then
	echo "build failed"
	exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation passed"
exit 0

// File: sources.f
+incdir+tb
verilog/wts_pkg.sv
verilog/wts_sequencer.sv
verilog/wts_wave_ram.sv
verilog/wts_voice_group.sv
verilog/wts_stereo_mixer.sv
verilog/wts_top.sv
tb/wts_tb.sv

// File: tb/wts_tb_checks.svh
`ifndef WTS_TB_CHECKS_SVH
`define WTS_TB_CHECKS_SVH

// ----------------------------------------------------------------------------
// expected-value model
// ----------------------------------------------------------------------------

// the sample each voice plays, and whether it is keyed on
logic signed [SAMPLE_W-1:0]	model_sample [VOICE_COUNT];
bit							model_playing [VOICE_COUNT];

// signed sample times unsigned volume, then an arithmetic shift by four
function automatic int contribution(input logic signed [SAMPLE_W-1:0] sample,
		input logic [VOLUME_W-1:0] volume);
	int product;
	product = int'(sample) * int'(volume);
	return product >>> VOLUME_W;
endfunction

// channel 1 is left and channel 0 is right, as in the enable field
function automatic logic [OUT_W-1:0] expected_output(input int channel);
	int total;
	voice_regs_t r;
	total = 0;
	for (int i = 0; i < VOICE_COUNT; i++) begin
		r = regs[i / VOICES_PER_GROUP][i % VOICES_PER_GROUP];
		if (model_playing[i] && r.enable[channel]) begin
			total += contribution(model_sample[i], r.volume);
		end
	end
	return OUT_SILENCE + OUT_W'(total);
endfunction

// ----------------------------------------------------------------------------
// random values
// ----------------------------------------------------------------------------

// a magnitude of at least 16 keeps the scaled value away from zero
function automatic logic signed [SAMPLE_W-1:0] random_sample(input bit negative);
	int magnitude;
	magnitude = int'($urandom_range(127, 16));
	return SAMPLE_W'(negative ? -magnitude : magnitude);
endfunction

function automatic logic [VOLUME_W-1:0] random_volume();
	return VOLUME_W'($urandom_range(15, 1));
endfunction

function automatic logic [1:0] random_enable();
	return 2'($urandom_range(3, 1));
endfunction

function automatic logic [FREQ_W-1:0] random_frequency();
	return FREQ_W'($urandom_range(4095, 1));
endfunction

// ----------------------------------------------------------------------------
// stimulus
// ----------------------------------------------------------------------------
task automatic write_sample(input int idx, input int addr,
		input logic [SAMPLE_W-1:0] value);
	wave_write_t w;
	w.group = 1'(idx / VOICES_PER_GROUP);
	w.voice = voice_index_t'(idx % VOICES_PER_GROUP);
	w.addr = WAVE_ADDR_W'(addr);
	w.data = value;
	@(posedge clk);
	wave_write_strobe <= 1'b1;
	wave_write <= w;
endtask

task automatic end_writes();
	@(posedge clk);
	wave_write_strobe <= 1'b0;
endtask

// writes go out back to back, one per cycle
task automatic fill_wave(input int idx, input logic signed [SAMPLE_W-1:0] value);
	for (int a = 0; a < (1 << WAVE_ADDR_W); a++) begin
		write_sample(idx, a, value);
	end
	end_writes();
	model_sample[idx] = value;
endtask

task automatic set_voice(input int idx, input logic [VOLUME_W-1:0] volume,
		input logic [1:0] enable, input logic [FREQ_W-1:0] frequency);
	voice_regs_t r;
	r.volume = volume;
	r.enable = enable;
	r.frequency_count = frequency;
	@(posedge clk);
	regs[idx / VOICES_PER_GROUP][idx % VOICES_PER_GROUP] <= r;
endtask

task automatic set_enable(input int idx, input logic [1:0] enable);
	voice_regs_t r;
	r = regs[idx / VOICES_PER_GROUP][idx % VOICES_PER_GROUP];
	r.enable = enable;
	@(posedge clk);
	regs[idx / VOICES_PER_GROUP][idx % VOICES_PER_GROUP] <= r;
endtask

// one-cycle strobe on key_on or key_off
task automatic pulse_key(input int idx, input bit on);
	logic [VOICE_COUNT-1:0] mask;
	mask = '0;
	mask[idx] = 1'b1;
	@(posedge clk);
	if (on) begin
		key_on <= mask;
	end else begin
		key_off <= mask;
	end
	@(posedge clk);
	key_on <= '0;
	key_off <= '0;
	model_playing[idx] = on;
endtask

// ----------------------------------------------------------------------------
// checks
// ----------------------------------------------------------------------------

// outputs settle within three frames, they are sampled after four
task automatic check_outputs(input string step);
	logic [OUT_W-1:0] exp_left;
	logic [OUT_W-1:0] exp_right;
	repeat (SETTLE_CYCLES) @(posedge clk);
	@(negedge clk);
	exp_left = expected_output(1);
	exp_right = expected_output(0);
	a_left_out: assert (left_out === exp_left) else begin
		left_errors++;
		$display("FAIL at time %0t: left_out expected 12'h%h, actual 12'h%h (%s)",
			$time, exp_left, left_out, step);
	end
	a_right_out: assert (right_out === exp_right) else begin
		right_errors++;
		$display("FAIL at time %0t: right_out expected 12'h%h, actual 12'h%h (%s)",
			$time, exp_right, right_out, step);
	end
endtask

`endif

// File: tb/wts_tb.sv
module wts_tb;
	import wts_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int VOICE_COUNT = GROUP_COUNT * VOICES_PER_GROUP;
	localparam int SETTLE_CYCLES = 4 * VOICES_PER_GROUP;
	localparam int SCENARIO_COUNT = 5;
	// forty frames for each scenario
	localparam int WATCHDOG_LIMIT = SCENARIO_COUNT * 40 * VOICES_PER_GROUP * CLOCK_PERIOD;
	localparam int SOLO_VOICE = 2;
	localparam int FIXED_VOICE = 9;
	localparam int MIXED_VOICES [4] = '{0, 4, 6, 11};

	logic							clk;
	logic							nreset;
	logic							wave_write_strobe;
	wave_write_t					wave_write;
	logic [VOICE_COUNT-1:0]			key_on;
	logic [VOICE_COUNT-1:0]			key_off;
	group_regs_t [GROUP_COUNT-1:0]	regs;
	logic [OUT_W-1:0]				left_out;
	logic [OUT_W-1:0]				right_out;

	int left_errors = 0;
	int right_errors = 0;

	`include "wts_tb_checks.svh"

	wts_top UUT (
		.clk				(clk),
		.nreset				(nreset),
		.wave_write_strobe	(wave_write_strobe),
		.wave_write			(wave_write),
		.key_on				(key_on),
		.key_off			(key_off),
		.regs				(regs),
		.left_out			(left_out),
		.right_out			(right_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_LIMIT);
		$display("timeout: the scenarios did not finish within %0d time units", WATCHDOG_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// scenarios
	// ------------------------------------------------------------------------
	task automatic run_idle();
		for (int i = 0; i < 3; i++) begin
			check_outputs("idle after reset");
		end
	endtask

	task automatic run_single_voice();
		logic signed [SAMPLE_W-1:0] value;
		value = random_sample($urandom_range(1, 0) == 1);
		fill_wave(SOLO_VOICE, value);
		set_voice(SOLO_VOICE, random_volume(), 2'b10, random_frequency());
		pulse_key(SOLO_VOICE, 1'b1);
		check_outputs("single voice, left only");
	endtask

	task automatic run_pan();
		set_enable(SOLO_VOICE, 2'b01);
		check_outputs("single voice, right only");
		set_enable(SOLO_VOICE, 2'b11);
		check_outputs("single voice, both sides");
		pulse_key(SOLO_VOICE, 1'b0);
		check_outputs("single voice released");
	endtask

	task automatic run_mixed();
		int idx;
		for (int i = 0; i < 4; i++) begin
			idx = MIXED_VOICES[i];
			// odd entries get negative waves
			fill_wave(idx, random_sample(i % 2 == 1));
			set_voice(idx, random_volume(), random_enable(), random_frequency());
		end
		for (int i = 0; i < 4; i++) begin
			pulse_key(MIXED_VOICES[i], 1'b1);
		end
		check_outputs("mixed voices in both groups");
		for (int i = 0; i < 4; i++) begin
			pulse_key(MIXED_VOICES[i], 1'b0);
		end
		check_outputs("mixed voices released");
	endtask

	// with a zero frequency the accumulator never leaves sample 0
	task automatic run_fixed_phase();
		logic signed [SAMPLE_W-1:0] start_value;
		logic signed [SAMPLE_W-1:0] other_value;
		logic signed [SAMPLE_W-1:0] new_value;
		start_value = random_sample(1'b0);
		other_value = random_sample(1'b1);
		new_value = random_sample(1'b1);
		fill_wave(FIXED_VOICE, other_value);
		write_sample(FIXED_VOICE, 0, start_value);
		end_writes();
		model_sample[FIXED_VOICE] = start_value;
		set_voice(FIXED_VOICE, random_volume(), 2'b11, '0);
		pulse_key(FIXED_VOICE, 1'b1);
		check_outputs("fixed phase, first sample 0");
		write_sample(FIXED_VOICE, 0, new_value);
		end_writes();
		model_sample[FIXED_VOICE] = new_value;
		check_outputs("fixed phase, rewritten sample 0");
	endtask

	initial begin
		void'($urandom(32'hb6b8506a));
		nreset <= 1'b0;
		wave_write_strobe <= 1'b0;
		wave_write <= '0;
		key_on <= '0;
		key_off <= '0;
		regs <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		nreset <= 1'b1;

		run_idle();
		run_single_voice();
		run_pan();
		run_mixed();
		run_fixed_phase();

		$display("errors: left_out %0d, right_out %0d", left_errors, right_errors);
		if (left_errors == 0 && right_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/wts_pkg.sv
package wts_pkg;

	// --------------------------------------------------------------------------
	// sizes
	// --------------------------------------------------------------------------
	localparam int VOICES_PER_GROUP = 6;
	localparam int GROUP_COUNT = 2;
	localparam int WAVE_ADDR_W = 5;
	localparam int SAMPLE_W = 8;
	localparam int VOLUME_W = 4;
	localparam int FREQ_W = 12;
	localparam int ACC_W = 16;
	localparam int OUT_W = 12;

	// offset binary, so the top bit alone marks zero
	localparam logic [OUT_W-1:0] OUT_SILENCE = 12'h800;

	// --------------------------------------------------------------------------
	// types
	// --------------------------------------------------------------------------
	typedef logic [$clog2(VOICES_PER_GROUP)-1:0] voice_index_t;

	// one-hot, bit k set while slot k is being handled
	typedef logic [VOICES_PER_GROUP-1:0] phase_t;

	typedef struct packed {
		logic [VOLUME_W-1:0] volume;
		// bit 1 is left, bit 0 is right
		logic [1:0] enable;
		logic [FREQ_W-1:0] frequency_count;
	} voice_regs_t;

	typedef voice_regs_t [VOICES_PER_GROUP-1:0] group_regs_t;

	typedef struct packed {
		logic group;
		voice_index_t voice;
		logic [WAVE_ADDR_W-1:0] addr;
		logic [SAMPLE_W-1:0] data;
	} wave_write_t;

	typedef struct packed {
		logic strobe;
		voice_index_t voice;
		logic [WAVE_ADDR_W-1:0] addr;
		logic [SAMPLE_W-1:0] data;
	} ram_write_t;

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] left;
		logic signed [SAMPLE_W-1:0] right;
		logic last;
	} voice_sample_t;

endpackage

// File: verilog/wts_sequencer.sv
module wts_sequencer (
	input	logic										clk,
	input	logic										nreset,
	input	logic										wave_write_strobe,
	input	wts_pkg::wave_write_t						wave_write,
	output	wts_pkg::phase_t							phase,
	output	wts_pkg::ram_write_t [wts_pkg::GROUP_COUNT-1:0]	ram_write
);
	import wts_pkg::*;

	logic			write_pending;
	wave_write_t	write_q;

	// --------------------------------------------------------------------------
	// slot ring
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			phase <= phase_t'(1);
		end else begin
			phase <= {phase[VOICES_PER_GROUP-2:0], phase[VOICES_PER_GROUP-1]};
		end
	end

	// --------------------------------------------------------------------------
	// cpu wave writes
	// --------------------------------------------------------------------------

	// the strobe lives for one cycle only, a new request may follow at once
	always_ff @(posedge clk) begin
		if (!nreset) begin
			write_pending <= 1'b0;
		end else begin
			write_pending <= wave_write_strobe;
		end
	end

	always_ff @(posedge clk) begin
		if (wave_write_strobe) begin
			write_q <= wave_write;
		end
	end

	// both groups see the address and data, only the addressed one is strobed
	always_comb begin
		for (int g = 0; g < GROUP_COUNT; g++) begin
			ram_write[g].strobe = write_pending && (write_q.group == 1'(g));
			ram_write[g].voice = write_q.voice;
			ram_write[g].addr = write_q.addr;
			ram_write[g].data = write_q.data;
		end
	end

	a_phase_onehot: assert property (
		@(posedge clk) disable iff (!nreset)
		$onehot(phase) ##1 $onehot(phase)
	) else $error("phase ring does not hold exactly one active slot");

	// a voice index of six or seven would land outside the wave memory
	a_write_voice: assert property (
		@(posedge clk) disable iff (!nreset)
		wave_write_strobe |-> (wave_write.voice < VOICES_PER_GROUP)
	) else $error("wave write to voice %0d, which does not exist", wave_write.voice);

endmodule

// File: verilog/wts_stereo_mixer.sv
module wts_stereo_mixer (
	input	logic											clk,
	input	logic											nreset,
	input	wts_pkg::voice_sample_t [wts_pkg::GROUP_COUNT-1:0]	group_sample,
	output	logic [wts_pkg::OUT_W-1:0]						left_out,
	output	logic [wts_pkg::OUT_W-1:0]						right_out
);
	import wts_pkg::*;

	logic					frame_end;
	logic [OUT_W-1:0]		left_sum;
	logic [OUT_W-1:0]		right_sum;
	logic [OUT_W-1:0]		left_total;
	logic [OUT_W-1:0]		right_total;
	logic [OUT_W-1:0]		left_integ;
	logic [OUT_W-1:0]		right_integ;

	assign frame_end = group_sample[0].last;

	// --------------------------------------------------------------------------
	// group sum
	// --------------------------------------------------------------------------

	// samples are widened with their sign before the add
	always_comb begin
		left_sum = '0;
		right_sum = '0;
		for (int g = 0; g < GROUP_COUNT; g++) begin
			left_sum = left_sum + OUT_W'(group_sample[g].left);
			right_sum = right_sum + OUT_W'(group_sample[g].right);
		end
		left_total = left_integ + left_sum;
		right_total = right_integ + right_sum;
	end

	// --------------------------------------------------------------------------
	// frame integrator and outputs
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_integ <= '0;
			right_integ <= '0;
		end else if (frame_end) begin
			left_integ <= '0;
			right_integ <= '0;
		end else begin
			left_integ <= left_total;
			right_integ <= right_total;
		end
	end

	// flipping the top bit turns two's complement into offset binary
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_out <= OUT_SILENCE;
			right_out <= OUT_SILENCE;
		end else if (frame_end) begin
			left_out <= left_total ^ OUT_SILENCE;
			right_out <= right_total ^ OUT_SILENCE;
		end
	end

	a_frames_aligned: assert property (
		@(posedge clk) disable iff (!nreset)
		group_sample[0].last == group_sample[1].last
	) else $error("voice groups disagree on the frame boundary");

endmodule

// File: verilog/wts_top.sv
module wts_top (
	input	logic													clk,
	input	logic													nreset,
	input	logic													wave_write_strobe,
	input	wts_pkg::wave_write_t									wave_write,
	input	logic [wts_pkg::GROUP_COUNT*wts_pkg::VOICES_PER_GROUP-1:0]	key_on,
	input	logic [wts_pkg::GROUP_COUNT*wts_pkg::VOICES_PER_GROUP-1:0]	key_off,
	input	wts_pkg::group_regs_t [wts_pkg::GROUP_COUNT-1:0]		regs,
	output	logic [wts_pkg::OUT_W-1:0]								left_out,
	output	logic [wts_pkg::OUT_W-1:0]								right_out
);
	import wts_pkg::*;

	phase_t							phase;
	ram_write_t [GROUP_COUNT-1:0]		ram_write;
	voice_sample_t [GROUP_COUNT-1:0]	group_sample;

	wts_sequencer u_sequencer (
		.clk				(clk),
		.nreset				(nreset),
		.wave_write_strobe	(wave_write_strobe),
		.wave_write			(wave_write),
		.phase				(phase),
		.ram_write			(ram_write)
	);

	// --------------------------------------------------------------------------
	// voice groups
	// --------------------------------------------------------------------------

	// key bit g*6+v belongs to voice v of group g
	for (genvar g = 0; g < GROUP_COUNT; g++) begin : g_group
		wts_voice_group u_voice_group (
			.clk			(clk),
			.nreset			(nreset),
			.phase			(phase),
			.regs			(regs[g]),
			.key_on			(key_on[g*VOICES_PER_GROUP +: VOICES_PER_GROUP]),
			.key_off		(key_off[g*VOICES_PER_GROUP +: VOICES_PER_GROUP]),
			.ram_write		(ram_write[g]),
			.voice_sample	(group_sample[g])
		);
	end

	wts_stereo_mixer u_stereo_mixer (
		.clk			(clk),
		.nreset			(nreset),
		.group_sample	(group_sample),
		.left_out		(left_out),
		.right_out		(right_out)
	);

endmodule

// File: verilog/wts_voice_group.sv
module wts_voice_group (
	input	logic									clk,
	input	logic									nreset,
	input	wts_pkg::phase_t						phase,
	input	wts_pkg::group_regs_t					regs,
	input	logic [wts_pkg::VOICES_PER_GROUP-1:0]	key_on,
	input	logic [wts_pkg::VOICES_PER_GROUP-1:0]	key_off,
	input	wts_pkg::ram_write_t					ram_write,
	output	wts_pkg::voice_sample_t					voice_sample
);
	import wts_pkg::*;

	logic [VOICES_PER_GROUP-1:0]				playing;
	logic [VOICES_PER_GROUP-1:0][ACC_W-1:0]	acc;
	voice_index_t								slot;
	logic [WAVE_ADDR_W-1:0]						read_addr;
	voice_index_t								slot_q;
	logic										live_q;
	logic signed [SAMPLE_W-1:0]					wave_data;
	voice_regs_t								slot_regs;
	logic signed [SAMPLE_W+VOLUME_W:0]			product;
	logic signed [SAMPLE_W-1:0]					scaled;

	function automatic voice_index_t slot_of(phase_t ring);
		voice_index_t index;
		index = '0;
		for (int i = 0; i < VOICES_PER_GROUP; i++) begin
			if (ring[i]) begin
				index = voice_index_t'(i);
			end
		end
		return index;
	endfunction

	assign slot = slot_of(phase);

	// --------------------------------------------------------------------------
	// key state and phase accumulators
	// --------------------------------------------------------------------------

	// keys act on any cycle, the accumulator only moves in its own slot
	always_ff @(posedge clk) begin
		if (!nreset) begin
			playing <= '0;
			acc <= '0;
		end else begin
			for (int v = 0; v < VOICES_PER_GROUP; v++) begin
				if (key_on[v]) begin
					playing[v] <= 1'b1;
					acc[v] <= '0;
				end else begin
					if (key_off[v]) begin
						playing[v] <= 1'b0;
					end
					if (phase[v] && playing[v]) begin
						acc[v] <= acc[v] + ACC_W'(regs[v].frequency_count);
					end
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// wave lookup
	// --------------------------------------------------------------------------
	assign read_addr = acc[slot][ACC_W-1 -: WAVE_ADDR_W];

	wts_wave_ram u_wave_ram (
		.clk		(clk),
		.ram_write	(ram_write),
		.read_voice	(slot),
		.read_addr	(read_addr),
		.read_data	(wave_data)
	);

	// slot number follows the memory read by one cycle
	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot_q <= '0;
			live_q <= 1'b0;
		end else begin
			slot_q <= slot;
			live_q <= playing[slot];
		end
	end

	// --------------------------------------------------------------------------
	// volume and pan
	// --------------------------------------------------------------------------
	assign slot_regs = regs[slot_q];

	// volume is unsigned, so it gets a zero sign bit before the signed multiply
	assign product = wave_data * $signed({1'b0, slot_regs.volume});
	assign scaled = SAMPLE_W'(product >>> VOLUME_W);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			voice_sample <= '0;
		end else begin
			voice_sample.left <= (live_q && slot_regs.enable[1]) ? scaled : '0;
			voice_sample.right <= (live_q && slot_regs.enable[0]) ? scaled : '0;
			voice_sample.last <= (slot_q == voice_index_t'(VOICES_PER_GROUP - 1));
		end
	end

	// the mixer closes its frame on this flag
	a_last_period: assert property (
		@(posedge clk) disable iff (!nreset)
		voice_sample.last |=> (!voice_sample.last) [*VOICES_PER_GROUP-1] ##1 voice_sample.last
	) else $error("last sample flag out of step with the six slot frame");

endmodule

// File: verilog/wts_wave_ram.sv
module wts_wave_ram (
	input	logic									clk,
	input	wts_pkg::ram_write_t					ram_write,
	input	wts_pkg::voice_index_t					read_voice,
	input	logic [wts_pkg::WAVE_ADDR_W-1:0]		read_addr,
	output	logic signed [wts_pkg::SAMPLE_W-1:0]	read_data
);
	import wts_pkg::*;

	// voice and sample index side by side form the address, 32 bytes per voice
	logic [SAMPLE_W-1:0] mem [VOICES_PER_GROUP << WAVE_ADDR_W];
	logic [$clog2(VOICES_PER_GROUP)+WAVE_ADDR_W-1:0] write_index;
	logic [$clog2(VOICES_PER_GROUP)+WAVE_ADDR_W-1:0] read_index;

	assign write_index = {ram_write.voice, ram_write.addr};
	assign read_index = {read_voice, read_addr};

	always_ff @(posedge clk) begin
		if (ram_write.strobe) begin
			mem[write_index] <= ram_write.data;
		end
	end

	// a read of the address being written returns the old byte
	always_ff @(posedge clk) begin
		read_data <= mem[read_index];
	end

endmodule
